/* Bender.yml */
package:
  name: frame_renderer

sources:
  - include_dirs:
      - include
    files:
      - rtl/game_pkg.sv
      - rtl/video_pkg.sv
      - rtl/pixel_if.sv
      - rtl/apb_game_regs.sv
      - rtl/frame_pacer.sv
      - rtl/frame_control.sv
      - rtl/sprite_draw.sv
      - rtl/score_draw.sv
      - rtl/frame_top.sv
  - target: test
    files:
      - test/tb_frame_top.sv

/* include/digit_glyphs.svh */
// 4x4 glyph lookup for decimal digits, msb is the top left pixel
`ifndef DIGIT_GLYPHS_SVH
`define DIGIT_GLYPHS_SVH

// rows top to bottom, 4 bits each, left pixel in the high bit of a row
function automatic logic [15:0] digit_glyph(input logic [3:0] digit);
	logic [15:0] glyph;
	case (digit)
		4'd0:    glyph = 16'b0110_1001_1001_0110;
		4'd1:    glyph = 16'b0110_1010_0010_1111;
		4'd2:    glyph = 16'b1110_0001_1110_1111;
		4'd3:    glyph = 16'b1111_0011_0001_1111;
		4'd4:    glyph = 16'b1001_1001_1111_0001;
		4'd5:    glyph = 16'b1111_1100_0011_1111;
		4'd6:    glyph = 16'b0111_1000_1011_1111;
		4'd7:    glyph = 16'b1111_0001_0010_0100;
		4'd8:    glyph = 16'b1110_1011_1101_0111;
		4'd9:    glyph = 16'b1110_1001_1111_0001;
		default: glyph = 16'b0110_1001_1001_0110;	// out of range shows as zero
	endcase
	return glyph;
endfunction

`endif

/* project.f */
+incdir+include
rtl/game_pkg.sv
rtl/video_pkg.sv
rtl/pixel_if.sv
rtl/apb_game_regs.sv
rtl/frame_pacer.sv
rtl/frame_control.sv
rtl/sprite_draw.sv
rtl/score_draw.sv
rtl/frame_top.sv
test/tb_frame_top.sv

/* rtl/apb_game_regs.sv */
// apb slave register file with high score tracking and per-frame state snapshot
`timescale 1ns/1ps
`default_nettype none

module apb_game_regs (
	input  logic                   clk,
	input  logic                   resetn,
	input  logic                   psel,
	input  logic                   penable,
	input  logic                   pwrite,
	input  game_pkg::apb_addr_t    paddr,
	input  game_pkg::apb_data_t    pwdata,
	output game_pkg::apb_data_t    prdata,
	output logic                   pready,
	output logic                   pslverr,
	input  logic                   frame_start,
	output game_pkg::game_state_t  state,	// frozen copy for the frame in flight
	output video_pkg::coord_y_t    prev_ball_y
);
	game_pkg::game_state_t live;	// host visible registers
	logic       access;
	logic       mapped;
	logic       wr_en;
	logic [6:0] score_sat;

	assign pready = 1'b1;	// zero wait states
	assign access = psel && penable;
	assign pslverr = access && (!mapped || (pwrite && paddr == game_pkg::REG_HISCORE));
	assign wr_en = access && pwrite && !pslverr;
	assign score_sat = (pwdata > game_pkg::SCORE_MAX) ? 7'(game_pkg::SCORE_MAX) : pwdata[6:0];

	// ------------------------------------------------------------
	// read mux and address decode
	always_comb begin
		mapped = 1'b1;
		prdata = '0;
		case (paddr)
			game_pkg::REG_BALL:        prdata = 32'({live.ball_colour, live.ball_y});
			game_pkg::REG_PLAT_Y:      prdata = 32'(live.plat_y);
			game_pkg::REG_PLAT_COLOUR: prdata = 32'(live.plat_colour);
			game_pkg::REG_SCORE:       prdata = 32'(live.score);
			game_pkg::REG_HISCORE:     prdata = 32'(live.hiscore);
			default:                   mapped = 1'b0;	// error response, reads zero
		endcase
	end

	// ------------------------------------------------------------
	// writes land one cycle after the access and frame_start loads the snapshot
	always_ff @(posedge clk) begin
		if (!resetn) begin
			live <= '0;
			state <= '0;
			prev_ball_y <= '0;	// first erase hits row 0
		end else begin
			if (wr_en) begin
				case (paddr)
					game_pkg::REG_BALL: begin
						live.ball_y <= pwdata[7:0];
						live.ball_colour <= pwdata[10:8];
					end
					game_pkg::REG_PLAT_Y:      live.plat_y <= pwdata[game_pkg::NUM_PLATS*8-1:0];
					game_pkg::REG_PLAT_COLOUR: live.plat_colour <= pwdata[game_pkg::NUM_PLATS*3-1:0];
					game_pkg::REG_SCORE: begin
						live.score <= score_sat;
						if (score_sat > live.hiscore)
							live.hiscore <= score_sat;	// keeps the best ever
					end
					default: ;
				endcase
			end
			if (frame_start) begin
				state <= live;	// a write in this cycle waits for the next frame
				prev_ball_y <= state.ball_y;	// row drawn last frame
			end
		end
	end

	// zero wait state slave
	a_no_wait: assert property (@(posedge clk) disable iff (!resetn) psel |-> pready);

endmodule

`default_nettype wire

/* rtl/frame_control.sv */
// frame phase fsm, drawer sequencing and registered pixel output
`timescale 1ns/1ps
`default_nettype none

module frame_control (
	input  logic                 clk,
	input  logic                 resetn,
	input  logic                 tick,
	output logic                 frame_start,
	output logic                 frame_busy,
	pixel_if.ctrl                sprite_if,
	pixel_if.ctrl                score_if,
	output logic                 plot,
	output video_pkg::coord_x_t  x,
	output video_pkg::coord_y_t  y,
	output video_pkg::colour_t   colour
);
	video_pkg::frame_phase_e phase;
	logic                sprite_start;
	logic                score_start;
	logic                sel_valid;
	video_pkg::coord_x_t sel_px;
	video_pkg::coord_y_t sel_py;
	video_pkg::colour_t  sel_colour;
	logic [7:0]          plot_cnt;	// plots in the current frame

	assign sprite_if.start = sprite_start;
	assign sprite_if.phase = phase;
	assign score_if.start = score_start;
	assign score_if.phase = phase;

	// only the score phase listens to score_draw
	always_comb begin
		if (phase == video_pkg::PH_DRAW_SCORES) begin
			sel_valid = score_if.valid;
			sel_px = score_if.px;
			sel_py = score_if.py;
			sel_colour = score_if.pcolour;
		end else begin
			sel_valid = sprite_if.valid;
			sel_px = sprite_if.px;
			sel_py = sprite_if.py;
			sel_colour = sprite_if.pcolour;
		end
	end

	// ------------------------------------------------------------
	// phase fsm, one idle cycle between a done and the next start
	always_ff @(posedge clk) begin
		if (!resetn) begin
			phase <= video_pkg::PH_IDLE;
			frame_start <= 1'b0;
			frame_busy <= 1'b0;
			sprite_start <= 1'b0;
			score_start <= 1'b0;
			plot <= 1'b0;
			plot_cnt <= '0;
		end else begin
			frame_start <= 1'b0;	// pulses by default
			sprite_start <= 1'b0;
			score_start <= 1'b0;
			plot <= sel_valid;	// pixel lags valid by one
			if (frame_start)
				plot_cnt <= '0;
			else if (plot)
				plot_cnt <= plot_cnt + 8'd1;
			case (phase)
				video_pkg::PH_IDLE: begin
					if (tick && !frame_busy) begin	// ticks during busy are dropped
						phase <= video_pkg::PH_ERASE_BALL;
						frame_start <= 1'b1;
						frame_busy <= 1'b1;
						sprite_start <= 1'b1;
					end else begin
						frame_busy <= 1'b0;	// last plot has gone out
					end
				end
				video_pkg::PH_ERASE_BALL: if (sprite_if.done) begin
					phase <= video_pkg::PH_DRAW_PLATS;
					sprite_start <= 1'b1;
				end
				video_pkg::PH_DRAW_PLATS: if (sprite_if.done) begin
					phase <= video_pkg::PH_DRAW_BALL;
					sprite_start <= 1'b1;
				end
				video_pkg::PH_DRAW_BALL: if (sprite_if.done) begin
					phase <= video_pkg::PH_DRAW_SCORES;
					score_start <= 1'b1;
				end
				video_pkg::PH_DRAW_SCORES: if (score_if.done)
					phase <= video_pkg::PH_IDLE;
				default: phase <= video_pkg::PH_IDLE;
			endcase
		end
	end

	// pixel payload
	always_ff @(posedge clk) begin
		x <= sel_px;
		y <= sel_py;
		colour <= sel_colour;
	end

	a_one_start: assert property (@(posedge clk) disable iff (!resetn)
		!(sprite_start && score_start));
	a_on_screen: assert property (@(posedge clk) disable iff (!resetn)
		plot |-> (x < video_pkg::SCREEN_W) && (y < video_pkg::SCREEN_H));
	// every frame hands exactly one full set of pixels to the frame buffer
	a_frame_len: assert property (@(posedge clk) disable iff (!resetn)
		$fell(frame_busy) |-> plot_cnt == video_pkg::PIXELS_PER_FRAME);

endmodule

`default_nettype wire

/* rtl/frame_pacer.sv */
// frame tick generator, period shrinks as the score rises
`timescale 1ns/1ps
`default_nettype none

module frame_pacer (
	input  logic       clk,
	input  logic       resetn,
	input  logic [6:0] score,
	output logic       tick
);
	game_pkg::pacer_cnt_t count;
	game_pkg::pacer_cnt_t period;

	// base period minus a fixed step per point, 202 cycles at the top score
	assign period = game_pkg::pacer_cnt_t'(game_pkg::FRAME_BASE_CYCLES
		- game_pkg::SCORE_STEP_CYCLES * score);

	always_ff @(posedge clk) begin
		if (!resetn) begin
			count <= '0;
			tick <= 1'b0;
		end else if (count == '0) begin
			tick <= 1'b1;
			count <= period - 1'b1;	// period cycles from tick to tick
		end else begin
			tick <= 1'b0;
			count <= count - 1'b1;
		end
	end

endmodule

`default_nettype wire

/* rtl/frame_top.sv */
// top level of the frame renderer, apb slave in and pixel stream out
`timescale 1ns/1ps
`default_nettype none

module frame_top (
	input  logic                 clk,
	input  logic                 resetn,
	// apb slave
	input  logic                 psel,
	input  logic                 penable,
	input  logic                 pwrite,
	input  game_pkg::apb_addr_t  paddr,
	input  game_pkg::apb_data_t  pwdata,
	output game_pkg::apb_data_t  prdata,
	output logic                 pready,
	output logic                 pslverr,
	// to the frame buffer
	output logic                 plot,
	output logic                 frame_busy,
	output video_pkg::coord_x_t  x,
	output video_pkg::coord_y_t  y,
	output video_pkg::colour_t   colour
);
	game_pkg::game_state_t state;	// snapshot for the frame in flight
	video_pkg::coord_y_t   prev_ball_y;
	logic                  frame_start;
	logic                  tick;

	pixel_if sprite_if ();
	pixel_if score_if ();

	apb_game_regs i_regs (
		.clk, .resetn, .psel, .penable, .pwrite, .paddr, .pwdata,
		.prdata, .pready, .pslverr,
		.frame_start, .state, .prev_ball_y
	);

	frame_pacer i_pacer (.clk, .resetn, .score(state.score), .tick);

	frame_control i_ctrl (
		.clk, .resetn, .tick, .frame_start, .frame_busy,
		.sprite_if(sprite_if.ctrl), .score_if(score_if.ctrl),
		.plot, .x, .y, .colour
	);

	sprite_draw i_sprite (
		.clk, .resetn, .port(sprite_if.drawer), .state, .prev_ball_y
	);

	score_draw i_score (
		.clk, .resetn, .port(score_if.drawer),
		.hiscore(state.hiscore), .score(state.score)
	);

endmodule

`default_nettype wire

/* rtl/game_pkg.sv */
// game state constants, apb register map, register enum and game state struct
`default_nettype none

package game_pkg;

	// ------------------------------------------------------------
	// apb bus types
	typedef logic [7:0]  apb_addr_t;
	typedef logic [31:0] apb_data_t;

	// register offsets, word aligned
	typedef enum logic [7:0] {
		REG_BALL        = 8'h00,	// [7:0] row, [10:8] colour
		REG_PLAT_Y      = 8'h04,	// one byte per platform, platform 0 lowest
		REG_PLAT_COLOUR = 8'h08,	// 3 bits per platform
		REG_SCORE       = 8'h0C,	// saturates at SCORE_MAX
		REG_HISCORE     = 8'h10	// read only
	} game_reg_e;

	// ------------------------------------------------------------
	localparam int NUM_PLATS         = 4;
	localparam int SCORE_MAX         = 99;
	localparam int FRAME_BASE_CYCLES = 400;	// frame period at score 0
	localparam int SCORE_STEP_CYCLES = 2;	// shaved off per score point

	typedef logic [8:0] pacer_cnt_t;	// wide enough for FRAME_BASE_CYCLES

	typedef struct packed {
		logic [7:0]                      ball_y;
		logic [2:0]                      ball_colour;
		logic [NUM_PLATS-1:0][7:0]       plat_y;
		logic [NUM_PLATS-1:0][2:0]       plat_colour;
		logic [6:0]                      score;
		logic [6:0]                      hiscore;
	} game_state_t;

endpackage

`default_nettype wire

/* rtl/pixel_if.sv */
// pixel stream interface between frame controller and a drawing unit
`timescale 1ns/1ps
`default_nettype none

interface pixel_if;
	logic                      start;	// one cycle pulse from controller
	video_pkg::frame_phase_e   phase;	// held for the whole phase
	logic                      valid;	// one pixel per cycle once started
	video_pkg::coord_x_t       px;
	video_pkg::coord_y_t       py;
	video_pkg::colour_t        pcolour;
	logic                      done;	// with the last pixel

	modport ctrl   (output start, phase, input valid, px, py, pcolour, done);
	modport drawer (input start, phase, output valid, px, py, pcolour, done);
endinterface

`default_nettype wire

/* rtl/score_draw.sv */
// decimal split and glyph walker for high score and score digits
`timescale 1ns/1ps
`default_nettype none

module score_draw (
	input  logic        clk,
	input  logic        resetn,
	pixel_if.drawer     port,
	input  logic [6:0]  hiscore,
	input  logic [6:0]  score
);
	`include "digit_glyphs.svh"

	logic        active;
	logic [3:0]  pix_cnt;	// pixel within glyph
	logic [1:0]  dig_cnt;	// hi tens, hi ones, score tens, score ones
	logic        last_pix;
	logic [3:0]  hi_tens;
	logic [3:0]  hi_ones;
	logic [3:0]  sc_tens;
	logic [3:0]  sc_ones;
	logic [3:0]  digit;
	logic [15:0] glyph;

	// values are at most 99 so the quotient fits in 4 bits
	assign hi_tens = 4'(hiscore / 7'd10);
	assign hi_ones = 4'(hiscore % 7'd10);
	assign sc_tens = 4'(score / 7'd10);
	assign sc_ones = 4'(score % 7'd10);

	assign last_pix = (pix_cnt == 4'(video_pkg::SPRITE_SIZE * video_pkg::SPRITE_SIZE - 1));
	assign port.valid = active;
	assign port.done = active && last_pix && (dig_cnt == 2'd3);

	always_ff @(posedge clk) begin
		if (!resetn) begin
			active <= 1'b0;
			pix_cnt <= '0;
			dig_cnt <= '0;
		end else if (port.start && port.phase == video_pkg::PH_DRAW_SCORES) begin
			active <= 1'b1;
			pix_cnt <= '0;
			dig_cnt <= '0;
		end else if (active) begin
			pix_cnt <= pix_cnt + 4'd1;
			if (last_pix) begin
				dig_cnt <= dig_cnt + 2'd1;
				if (port.done)
					active <= 1'b0;
			end
		end
	end

	// ------------------------------------------------------------
	// digit select and placement
	always_comb begin
		case (dig_cnt)
			2'd0:    digit = hi_tens;
			2'd1:    digit = hi_ones;
			2'd2:    digit = sc_tens;
			default: digit = sc_ones;
		endcase
		glyph = digit_glyph(digit);
		port.px = video_pkg::coord_x_t'((dig_cnt[0] ? video_pkg::DIGIT_X_ONES
			: video_pkg::DIGIT_X_TENS) + pix_cnt[1:0]);
		port.py = video_pkg::coord_y_t'((dig_cnt[1] ? video_pkg::DIGIT_Y_SCORE
			: video_pkg::DIGIT_Y_HISCORE) + pix_cnt[3:2]);
		// ~pix_cnt picks bit 15-k
		port.pcolour = glyph[~pix_cnt] ? video_pkg::COLOUR_WHITE : video_pkg::COLOUR_BLACK;
	end

endmodule

`default_nettype wire

/* rtl/sprite_draw.sv */
// pixel walker for ball erase, platform draw and ball draw
`timescale 1ns/1ps
`default_nettype none

module sprite_draw (
	input  logic                   clk,
	input  logic                   resetn,
	pixel_if.drawer                port,
	input  game_pkg::game_state_t  state,
	input  video_pkg::coord_y_t    prev_ball_y
);
	logic       active;
	logic [3:0] pix_cnt;	// pixel within ball or platform
	logic [1:0] plat_cnt;	// platform 0..3
	logic       plat_phase;
	logic       last_pix;

	assign plat_phase = (port.phase == video_pkg::PH_DRAW_PLATS);
	// a 4x4 ball and a 16x1 platform both take 16 pixels
	assign last_pix = (pix_cnt == 4'(video_pkg::PLAT_LEN - 1));

	assign port.valid = active;
	assign port.done = active && last_pix && (!plat_phase || plat_cnt == 2'd3);

	// ------------------------------------------------------------
	// counters
	always_ff @(posedge clk) begin
		if (!resetn) begin
			active <= 1'b0;
			pix_cnt <= '0;
			plat_cnt <= '0;
		end else if (port.start) begin
			active <= 1'b1;
			pix_cnt <= '0;
			plat_cnt <= '0;
		end else if (active) begin
			pix_cnt <= pix_cnt + 4'd1;	// wraps into the next platform
			if (last_pix) begin
				if (port.done)
					active <= 1'b0;
				else
					plat_cnt <= plat_cnt + 2'd1;
			end
		end
	end

	// ------------------------------------------------------------
	// pixel position and colour with the ball walked row by row
	always_comb begin
		port.px = video_pkg::coord_x_t'(video_pkg::BALL_X + pix_cnt[1:0]);
		port.py = video_pkg::coord_y_t'(prev_ball_y + pix_cnt[3:2]);	// erase
		port.pcolour = video_pkg::COLOUR_BLACK;
		case (port.phase)
			video_pkg::PH_DRAW_PLATS: begin	// 16x1 line left of the ball column
				port.px = video_pkg::coord_x_t'(video_pkg::BALL_X
					- video_pkg::PLAT_X_OFFSET + pix_cnt);
				port.py = state.plat_y[plat_cnt];
				port.pcolour = state.plat_colour[plat_cnt];
			end
			video_pkg::PH_DRAW_BALL: begin
				port.py = video_pkg::coord_y_t'(state.ball_y + pix_cnt[3:2]);
				port.pcolour = state.ball_colour;
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

/* rtl/video_pkg.sv */
// screen geometry, sprite sizes, colours and frame phase enum
`default_nettype none

package video_pkg;

	typedef logic [7:0] coord_x_t;
	typedef logic [7:0] coord_y_t;
	typedef logic [2:0] colour_t;	// one bit per channel

	localparam int SCREEN_W         = 160;
	localparam int SCREEN_H         = 120;
	localparam int BALL_X           = 60;	// ball column is fixed
	localparam int PLAT_X_OFFSET    = 6;	// platforms start left of the ball
	localparam int SPRITE_SIZE      = 4;	// ball and glyphs are 4x4
	localparam int PLAT_LEN         = 16;
	localparam int DIGIT_X_TENS     = 100;
	localparam int DIGIT_X_ONES     = 105;
	localparam int DIGIT_Y_HISCORE  = 20;
	localparam int DIGIT_Y_SCORE    = 30;
	localparam colour_t COLOUR_BLACK = 3'd0;
	localparam colour_t COLOUR_WHITE = 3'd7;
	localparam int PIXELS_PER_FRAME = 160;	// 16 erase + 64 plats + 16 ball + 64 score

	typedef enum logic [2:0] {
		PH_IDLE, PH_ERASE_BALL, PH_DRAW_PLATS, PH_DRAW_BALL, PH_DRAW_SCORES
	} frame_phase_e;

endpackage

`default_nettype wire

/* test/tb_frame_top.sv */
// testbench for frame_top with random apb traffic, frame capture and a reference model
`timescale 1ns/1ps
`default_nettype none

module tb_frame_top;

	logic                 clk;
	logic                 resetn;
	logic                 psel;
	logic                 penable;
	logic                 pwrite;
	game_pkg::apb_addr_t  paddr;
	game_pkg::apb_data_t  pwdata;
	game_pkg::apb_data_t  prdata;
	logic                 pready;
	logic                 pslverr;
	logic                 plot;
	logic                 frame_busy;
	video_pkg::coord_x_t  x;
	video_pkg::coord_y_t  y;
	video_pkg::colour_t   colour;

	integer seed;
	integer errors;
	integer test_errors;	// error count when the current test began
	integer tests_run;
	integer tests_failed;
	integer cycle;

	// shadow of the host visible registers
	logic [7:0]  sh_ball_y;
	logic [2:0]  sh_ball_col;
	logic [31:0] sh_plat_y;
	logic [11:0] sh_plat_col;
	logic [6:0]  sh_score;
	logic [6:0]  sh_hiscore;

	// frame model
	logic [7:0]  prev_row;	// ball row of the previous snapshot
	logic [6:0]  score_m1;	// snapshot score of the last frame
	logic [6:0]  score_m2;	// and of the frame before, which paces the gap
	logic [15:0] glyph_rom [0:9];
	logic [7:0]  exp_x [0:159];
	logic [7:0]  exp_y [0:159];
	logic [2:0]  exp_c [0:159];
	integer      pix_idx;
	logic        busy_q;
	integer      rises;
	integer      last_rise;
	integer      last_gap;
	integer      frames_done;

	frame_top i_dut (
		.clk, .resetn, .psel, .penable, .pwrite, .paddr, .pwdata,
		.prdata, .pready, .pslverr,
		.plot, .frame_busy, .x, .y, .colour
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;	// 100 MHz
	end

	// ------------------------------------------------------------
	// error reporting
	task automatic report_mismatch(input string name, input logic [31:0] exp_v,
		input logic [31:0] act_v);
		$display("FAIL t=%0t %s expected %0h actual %0h", $time, name, exp_v, act_v);
		errors = errors + 1;
	endtask

	task automatic report_text(input string msg);
		$display("FAIL t=%0t %s", $time, msg);
		errors = errors + 1;
	endtask

	task automatic abort_run(input string msg);
		$display("TIMEOUT t=%0t %s", $time, msg);
		$display("RESULT: FAIL");
		$finish;
	endtask

	task automatic start_test;
		test_errors = errors;
	endtask

	task automatic end_test(input string name);
		tests_run = tests_run + 1;
		if (errors == test_errors) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: %0d errors", name, errors - test_errors);
			tests_failed = tests_failed + 1;
		end
	endtask

	// ------------------------------------------------------------
	// reference model
	function automatic logic expect_error(input logic wr, input logic [7:0] addr);
		logic mapped;
		mapped = (addr == game_pkg::REG_BALL) || (addr == game_pkg::REG_PLAT_Y)
			|| (addr == game_pkg::REG_PLAT_COLOUR) || (addr == game_pkg::REG_SCORE)
			|| (addr == game_pkg::REG_HISCORE);
		return !mapped || (wr && addr == game_pkg::REG_HISCORE);	// hiscore is read only
	endfunction

	function automatic logic [31:0] expected_read(input logic [7:0] addr);
		case (addr)
			game_pkg::REG_BALL:        return {21'd0, sh_ball_col, sh_ball_y};
			game_pkg::REG_PLAT_Y:      return sh_plat_y;
			game_pkg::REG_PLAT_COLOUR: return {20'd0, sh_plat_col};
			game_pkg::REG_SCORE:       return {25'd0, sh_score};
			game_pkg::REG_HISCORE:     return {25'd0, sh_hiscore};
			default:                   return 32'd0;
		endcase
	endfunction

	task automatic model_write(input logic [7:0] addr, input logic [31:0] data);
		case (addr)
			game_pkg::REG_BALL: begin
				sh_ball_y = data[7:0];
				sh_ball_col = data[10:8];
			end
			game_pkg::REG_PLAT_Y:      sh_plat_y = data;
			game_pkg::REG_PLAT_COLOUR: sh_plat_col = data[11:0];
			game_pkg::REG_SCORE: begin
				sh_score = (data > 32'd99) ? 7'd99 : data[6:0];	// saturate
				if (sh_score > sh_hiscore)
					sh_hiscore = sh_score;
			end
			default: ;
		endcase
	endtask

	// expected 160 plots from the shadow as it stands when the frame begins
	task automatic build_expected;
		integer k;
		integer p;
		integer d;
		integer n;
		logic [3:0]  digit;
		logic [15:0] g;
		n = 0;
		for (k = 0; k < 16; k = k + 1) begin	// erase, row by row
			exp_x[n] = video_pkg::BALL_X + k % 4;
			exp_y[n] = prev_row + k / 4;
			exp_c[n] = video_pkg::COLOUR_BLACK;
			n = n + 1;
		end
		for (p = 0; p < 4; p = p + 1) begin
			for (k = 0; k < 16; k = k + 1) begin
				exp_x[n] = video_pkg::BALL_X - video_pkg::PLAT_X_OFFSET + k;
				exp_y[n] = sh_plat_y[p*8 +: 8];
				exp_c[n] = sh_plat_col[p*3 +: 3];
				n = n + 1;
			end
		end
		for (k = 0; k < 16; k = k + 1) begin	// new ball
			exp_x[n] = video_pkg::BALL_X + k % 4;
			exp_y[n] = sh_ball_y + k / 4;
			exp_c[n] = sh_ball_col;
			n = n + 1;
		end
		for (d = 0; d < 4; d = d + 1) begin
			case (d)
				0:       digit = sh_hiscore / 10;
				1:       digit = sh_hiscore % 10;
				2:       digit = sh_score / 10;
				default: digit = sh_score % 10;
			endcase
			g = glyph_rom[digit];
			for (k = 0; k < 16; k = k + 1) begin
				exp_x[n] = ((d % 2) ? video_pkg::DIGIT_X_ONES : video_pkg::DIGIT_X_TENS) + k % 4;
				exp_y[n] = ((d < 2) ? video_pkg::DIGIT_Y_HISCORE : video_pkg::DIGIT_Y_SCORE)
					+ k / 4;
				exp_c[n] = g[15-k] ? video_pkg::COLOUR_WHITE : video_pkg::COLOUR_BLACK;
				n = n + 1;
			end
		end
		prev_row = sh_ball_y;	// erased next frame
	endtask

	// ------------------------------------------------------------
	// per cycle pixel monitor, runs right after each sampled edge
	task automatic watch_pixels;
		if (frame_busy && !busy_q) begin
			if (rises > 0) begin
				last_gap = cycle - last_rise;
				// pacer reloads from the snapshot held when it fires
				if (last_gap != game_pkg::FRAME_BASE_CYCLES
					- game_pkg::SCORE_STEP_CYCLES * score_m2)
					report_mismatch("frame period", game_pkg::FRAME_BASE_CYCLES
						- game_pkg::SCORE_STEP_CYCLES * score_m2, last_gap);
			end
			last_rise = cycle;
			rises = rises + 1;
			build_expected();
			score_m2 = score_m1;
			score_m1 = sh_score;
			pix_idx = 0;
		end
		if (plot) begin
			if (!frame_busy) begin
				report_text("plot high outside a frame");
			end else if (pix_idx >= video_pkg::PIXELS_PER_FRAME) begin
				report_text("more plots than one frame holds");
			end else begin
				if (x !== exp_x[pix_idx])
					report_mismatch("x", exp_x[pix_idx], x);
				if (y !== exp_y[pix_idx])
					report_mismatch("y", exp_y[pix_idx], y);
				if (colour !== exp_c[pix_idx])
					report_mismatch("colour", exp_c[pix_idx], colour);
			end
			pix_idx = pix_idx + 1;
		end
		if (!frame_busy && busy_q) begin
			if (pix_idx != video_pkg::PIXELS_PER_FRAME)
				report_mismatch("plot count", video_pkg::PIXELS_PER_FRAME, pix_idx);
			frames_done = frames_done + 1;
		end
		busy_q = frame_busy;
	endtask

	task automatic step;
		@(posedge clk);
		#1;	// inputs change here
		cycle = cycle + 1;
		watch_pixels();
	endtask

	// ------------------------------------------------------------
	// apb master
	task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] data,
		output logic [31:0] rdata, output logic err);
		psel = 1'b1;	// setup
		penable = 1'b0;
		pwrite = wr;
		paddr = addr;
		pwdata = data;
		step();
		penable = 1'b1;	// access
		#1;
		rdata = prdata;
		err = pslverr;
		if (pready !== 1'b1)
			report_text("pready low during an access");
		if (wr && !expect_error(wr, addr))
			model_write(addr, data);	// lands at the coming edge
		step();
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
		logic [31:0] rdata;
		logic        err;
		logic        exp_err;
		exp_err = expect_error(1'b1, addr);
		apb_access(1'b1, addr, data, rdata, err);
		if (err !== exp_err)
			report_mismatch("pslverr", exp_err, err);
	endtask

	task automatic read_check(input logic [7:0] addr);
		logic [31:0] rdata;
		logic        err;
		logic        exp_err;
		exp_err = expect_error(1'b0, addr);
		apb_access(1'b0, addr, 32'd0, rdata, err);
		if (err !== exp_err)
			report_mismatch("pslverr", exp_err, err);
		if (!exp_err && rdata !== expected_read(addr))
			report_mismatch("prdata", expected_read(addr), rdata);
	endtask

	task automatic read_all;
		read_check(game_pkg::REG_BALL);
		read_check(game_pkg::REG_PLAT_Y);
		read_check(game_pkg::REG_PLAT_COLOUR);
		read_check(game_pkg::REG_SCORE);
		read_check(game_pkg::REG_HISCORE);
	endtask

	// ------------------------------------------------------------
	// random values that keep every sprite on screen
	function automatic logic [31:0] random_ball;
		logic [31:0] r;
		r = $random(seed);
		r[7:0] = $unsigned($random(seed)) % 117;	// ball bottom row stays below 120
		return r;
	endfunction

	function automatic logic [31:0] random_plats;
		logic [31:0] r;
		integer p;
		for (p = 0; p < 4; p = p + 1)
			r[p*8 +: 8] = $unsigned($random(seed)) % 120;
		return r;
	endfunction

	function automatic logic [7:0] random_unmapped;
		logic [7:0] a;
		a = $random(seed);
		while (!expect_error(1'b0, a))
			a = a + 8'd1;
		return a;
	endfunction

	task automatic random_state;
		write_reg(game_pkg::REG_BALL, random_ball());
		write_reg(game_pkg::REG_PLAT_Y, random_plats());
		write_reg(game_pkg::REG_PLAT_COLOUR, $random(seed));
	endtask

	// ------------------------------------------------------------
	// waits
	task automatic wait_frames(input integer n);
		integer target;
		integer guard;
		target = frames_done + n;
		guard = 0;
		while (frames_done < target && guard < n * 500) begin
			step();
			guard = guard + 1;
		end
		if (frames_done < target)
			abort_run("frame did not complete in time");
	endtask

	task automatic wait_busy(input logic level);
		integer guard;
		guard = 0;
		while (frame_busy !== level && guard < 1000) begin
			step();
			guard = guard + 1;
		end
		if (frame_busy !== level)
			abort_run("frame_busy did not reach the expected level");
	endtask

	// ------------------------------------------------------------
	initial begin
		integer i;
		integer op;
		integer g0;
		integer g1;
		logic [31:0] r;
		logic [7:0]  a;
		logic [31:0] score_list [0:5];

		seed = 3;
		errors = 0;
		test_errors = 0;
		tests_run = 0;
		tests_failed = 0;
		cycle = 0;
		sh_ball_y = '0;
		sh_ball_col = '0;
		sh_plat_y = '0;
		sh_plat_col = '0;
		sh_score = '0;
		sh_hiscore = '0;
		prev_row = '0;
		score_m1 = '0;
		score_m2 = '0;
		pix_idx = 0;
		busy_q = 1'b0;
		rises = 0;
		last_rise = 0;
		last_gap = 0;
		frames_done = 0;
		// 4x4 digit patterns, top row in the high nibble
		glyph_rom[0] = 16'b0110_1001_1001_0110;
		glyph_rom[1] = 16'b0110_1010_0010_1111;
		glyph_rom[2] = 16'b1110_0001_1110_1111;
		glyph_rom[3] = 16'b1111_0011_0001_1111;
		glyph_rom[4] = 16'b1001_1001_1111_0001;
		glyph_rom[5] = 16'b1111_1100_0011_1111;
		glyph_rom[6] = 16'b0111_1000_1011_1111;
		glyph_rom[7] = 16'b1111_0001_0010_0100;
		glyph_rom[8] = 16'b1110_1011_1101_0111;
		glyph_rom[9] = 16'b1110_1001_1111_0001;
		resetn = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;

		// reset state and zero registers
		start_test();
		repeat (3) step();
		if (plot !== 1'b0)
			report_mismatch("plot", 1'b0, plot);
		if (frame_busy !== 1'b0)
			report_mismatch("frame_busy", 1'b0, frame_busy);
		resetn = 1'b1;
		read_all();
		end_test("reset");

		// random register traffic with full readback after each access
		start_test();
		for (i = 0; i < 40; i = i + 1) begin
			op = $unsigned($random(seed)) % 6;
			r = $random(seed);
			case (op)
				0: write_reg(game_pkg::REG_BALL, random_ball());
				1: write_reg(game_pkg::REG_PLAT_Y, random_plats());
				2: write_reg(game_pkg::REG_PLAT_COLOUR, r);
				3: write_reg(game_pkg::REG_SCORE, r[1:0] == 2'd0 ? r : r % 110);
				4: write_reg(game_pkg::REG_HISCORE, r);	// must be refused
				default: begin
					a = random_unmapped();
					if (r[0])
						write_reg(a, $random(seed));
					else
						read_check(a);
				end
			endcase
			read_all();
		end
		end_test("register access");

		// frames with fresh sprite state, written while idle
		start_test();
		for (i = 0; i < 4; i = i + 1) begin
			wait_busy(1'b0);
			random_state();
			wait_frames(1);
		end
		end_test("sprite frames");

		// score glyphs, edge values first
		start_test();
		score_list[0] = 0;
		score_list[1] = 9;
		score_list[2] = 10;
		score_list[3] = $unsigned($random(seed)) % 99;
		score_list[4] = $unsigned($random(seed)) % 99;
		score_list[5] = 99;
		for (i = 0; i < 6; i = i + 1) begin
			wait_busy(1'b0);
			write_reg(game_pkg::REG_SCORE, score_list[i]);
			wait_frames(1);
		end
		end_test("score glyphs");

		// writes during a frame must wait for the next snapshot
		start_test();
		for (i = 0; i < 3; i = i + 1) begin
			wait_busy(1'b0);
			wait_busy(1'b1);
			random_state();
			write_reg(game_pkg::REG_SCORE, $unsigned($random(seed)) % 100);
			if (frame_busy !== 1'b1)
				report_text("frame ended before the mid-frame writes were done");
			wait_frames(2);
		end
		end_test("mid-frame writes");

		// frame pacing at low and high score
		start_test();
		write_reg(game_pkg::REG_SCORE, 32'd0);
		wait_frames(3);
		g0 = last_gap;
		write_reg(game_pkg::REG_SCORE, 32'd60);
		wait_frames(3);
		g1 = last_gap;
		if (g1 >= g0)
			report_text("frame period did not shrink after the score rose");
		end_test("frame pacing");

		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire
